/* verilog/tracker_defs.svh */
`ifndef TRACKER_DEFS_SVH
`define TRACKER_DEFS_SVH

// default frame geometry of the camera stream
`define TRK_FRAME_WIDTH 320
`define TRK_FRAME_HEIGHT 180

// column and row counter widths
`define TRK_HCOUNT_W 9
`define TRK_VCOUNT_W 8

// inclusive red-difference chroma window, tuned for pink markers
`define TRK_CR_LOWER 8'd160
`define TRK_CR_UPPER 8'd240

// clocks per uart bit, 230400 baud from 200 MHz
`define TRK_BAUD_DIV 868

// report period in clocks and the count inside it where a report starts
`define TRK_REPORT_PERIOD 57600
`define TRK_REPORT_SLOT 14400

`endif

/* verilog/tracker_pkg.sv */
package tracker_pkg;

   `include "tracker_defs.svh"

   // column and row indices
   typedef logic [`TRK_HCOUNT_W-1:0] hcount_t;
   typedef logic [`TRK_VCOUNT_W-1:0] vcount_t;

   // colour view of a pixel word
   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_t;

   // bus view, first byte on the wire is the high byte
   typedef struct packed {
      logic [7:0] first;
      logic [7:0] second;
   } pixel_bytes_t;

   // same 16 bits, read as bus bytes or as colour fields
   typedef union packed {
      rgb565_t      rgb;
      pixel_bytes_t bus;
   } camera_pixel_u;

endpackage

/* verilog/camera_pixel_capture.sv */
module camera_pixel_capture (
   input  logic                      clk_camera,
   input  logic                      sys_rst_camera,
   input  logic [7:0]                camera_d_i,
   input  logic                      cam_pclk_i,
   input  logic                      cam_hsync_i,
   input  logic                      cam_vsync_i,
   output logic                      pix_valid_o,
   output tracker_pkg::camera_pixel_u pixel_o,
   output tracker_pkg::hcount_t      hcount_o,
   output tracker_pkg::vcount_t      vcount_o
);
   import tracker_pkg::*;

   // two-flop synchronizers, index 1 is the stable copy
   logic [7:0] d_sync [1:0];
   logic [1:0] pclk_sync;
   logic [1:0] href_sync;
   logic [1:0] vsync_sync;

   logic       pclk_prev;
   logic       href_prev;
   logic       pclk_rise;
   logic       href_fall;
   logic       phase;
   logic [7:0] high_byte;
   hcount_t    col_cnt;
   vcount_t    row_cnt;

   always_ff @(posedge clk_camera) begin
      d_sync     <= '{d_sync[0], camera_d_i};
      pclk_sync  <= {pclk_sync[0], cam_pclk_i};
      href_sync  <= {href_sync[0], cam_hsync_i};
      vsync_sync <= {vsync_sync[0], cam_vsync_i};
   end

   assign pclk_rise = pclk_sync[1] && !pclk_prev;
   assign href_fall = !href_sync[1] && href_prev;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_prev   <= 1'b0;
         href_prev   <= 1'b0;
         phase       <= 1'b0;
         col_cnt     <= '0;
         row_cnt     <= '0;
         pix_valid_o <= 1'b0;
         hcount_o    <= '0;
         vcount_o    <= '0;
      end else begin
         pclk_prev   <= pclk_sync[1];
         href_prev   <= href_sync[1];
         pix_valid_o <= 1'b0;
         if (vsync_sync[1]) begin
            // frame restart
            phase   <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
         end else if (href_fall) begin
            // end of line, next row
            phase   <= 1'b0;
            col_cnt <= '0;
            row_cnt <= row_cnt + 1'b1;
         end else if (pclk_rise && href_sync[1]) begin
            phase <= !phase;
            if (phase) begin
               // second byte completes the pixel
               pix_valid_o <= 1'b1;
               hcount_o    <= col_cnt;
               vcount_o    <= row_cnt;
               col_cnt     <= col_cnt + 1'b1;
            end
         end
      end
   end

   // payload, written through the byte view of the union
   always_ff @(posedge clk_camera) begin
      if (pclk_rise && href_sync[1]) begin
         if (!phase) begin
            high_byte <= d_sync[1];
         end else begin
            pixel_o.bus.first  <= high_byte;
            pixel_o.bus.second <= d_sync[1];
         end
      end
   end

endmodule

/* verilog/chroma_threshold.sv */
`include "tracker_defs.svh"

module chroma_threshold (
   input  logic                       clk_camera,
   input  logic                       sys_rst_camera,
   input  logic                       pix_valid_i,
   input  tracker_pkg::camera_pixel_u pixel_i,
   input  tracker_pkg::hcount_t       hcount_i,
   input  tracker_pkg::vcount_t       vcount_i,
   output logic                       mask_valid_o,
   output logic                       mask_o,
   output tracker_pkg::hcount_t       hcount_o,
   output tracker_pkg::vcount_t       vcount_o
);
   import tracker_pkg::*;

   logic [7:0]        red8;
   logic [7:0]        green8;
   logic [7:0]        blue8;
   logic signed [17:0] cr_sum;
   logic signed [17:0] cr_offset;
   logic [7:0]        cr_clamped;

   // stage one registers
   logic              valid_s1;
   logic [7:0]        cr_s1;
   hcount_t           hcount_s1;
   vcount_t           vcount_s1;

   // rgb565 widened to 8 bits, low bits zero
   assign red8   = {pixel_i.rgb.red, 3'b000};
   assign green8 = {pixel_i.rgb.green, 2'b00};
   assign blue8  = {pixel_i.rgb.blue, 3'b000};

   always_comb begin
      // fixed point cr, coefficients scaled by 256
      cr_sum = 18'sd112 * $signed({10'd0, red8})
             - 18'sd94 * $signed({10'd0, green8})
             - 18'sd18 * $signed({10'd0, blue8});
      cr_offset = (cr_sum >>> 8) + 18'sd128;
      // saturate to a byte
      if (cr_offset < 0) begin
         cr_clamped = 8'd0;
      end else if (cr_offset > 18'sd255) begin
         cr_clamped = 8'd255;
      end else begin
         cr_clamped = cr_offset[7:0];
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         valid_s1     <= 1'b0;
         mask_valid_o <= 1'b0;
      end else begin
         valid_s1     <= pix_valid_i;
         mask_valid_o <= valid_s1;
      end
   end

   // counts ride alongside the chroma
   always_ff @(posedge clk_camera) begin
      cr_s1     <= cr_clamped;
      hcount_s1 <= hcount_i;
      vcount_s1 <= vcount_i;
      // inclusive window on both ends
      mask_o    <= (cr_s1 >= `TRK_CR_LOWER) && (cr_s1 <= `TRK_CR_UPPER);
      hcount_o  <= hcount_s1;
      vcount_o  <= vcount_s1;
   end

endmodule

/* verilog/centroid_accumulator.sv */
`include "tracker_defs.svh"

module centroid_accumulator #(
   parameter int FRAME_WIDTH  = `TRK_FRAME_WIDTH,
   parameter int FRAME_HEIGHT = `TRK_FRAME_HEIGHT
) (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  logic                 mask_valid_i,
   input  logic                 mask_i,
   input  tracker_pkg::hcount_t hcount_i,
   input  tracker_pkg::vcount_t vcount_i,
   output tracker_pkg::hcount_t centroid_x_o,
   output tracker_pkg::vcount_t centroid_y_o,
   output logic                 centroid_valid_o
);
   import tracker_pkg::*;

   localparam int HW     = $bits(hcount_t);
   localparam int VW     = $bits(vcount_t);
   localparam int CNT_W  = $clog2(FRAME_WIDTH * FRAME_HEIGHT + 1);
   localparam int SX_W   = CNT_W + HW;
   localparam int SY_W   = CNT_W + VW;
   localparam int STEP_W = $clog2(SX_W + 1);

   // one restoring step, returns {new remainder, quotient bit}
   function automatic logic [CNT_W:0] div_step(input logic [CNT_W-1:0] rem,
                                                input logic din,
                                                input logic [CNT_W-1:0] dsr);
      logic [CNT_W:0] trial;
      logic [CNT_W:0] diff;
      trial = {rem, din};
      diff  = trial - {1'b0, dsr};
      if (trial >= {1'b0, dsr}) begin
         return {diff[CNT_W-1:0], 1'b1};
      end
      return {trial[CNT_W-1:0], 1'b0};
   endfunction

   logic [SX_W-1:0]   sum_x;
   logic [SY_W-1:0]   sum_y;
   logic [CNT_W-1:0]  count;
   logic [SX_W-1:0]   tot_x;
   logic [SY_W-1:0]   tot_y;
   logic [CNT_W-1:0]  tot_n;
   logic              hit;
   logic              last_pix;
   logic              start;
   logic              busy;
   logic              div_run;
   logic [STEP_W-1:0] step;

   // divider datapath, y dividend widened to the x length
   logic [SX_W-1:0]   dvd_x;
   logic [SX_W-1:0]   dvd_y;
   logic [CNT_W-1:0]  divisor;
   logic [CNT_W-1:0]  rem_x;
   logic [CNT_W-1:0]  rem_y;
   logic [CNT_W:0]    nxt_x;
   logic [CNT_W:0]    nxt_y;

   always_comb begin
      hit      = mask_valid_i && mask_i;
      last_pix = mask_valid_i && (hcount_i == HW'(FRAME_WIDTH - 1))
                 && (vcount_i == VW'(FRAME_HEIGHT - 1));
      // running totals including the current pixel
      tot_x    = sum_x + (hit ? SX_W'(hcount_i) : '0);
      tot_y    = sum_y + (hit ? SY_W'(vcount_i) : '0);
      tot_n    = count + CNT_W'(hit);
      // empty frame keeps the old centre
      start    = last_pix && (tot_n != '0);
      div_run  = busy && (step != STEP_W'(SX_W));
      nxt_x    = div_step(rem_x, dvd_x[SX_W-1], divisor);
      nxt_y    = div_step(rem_y, dvd_y[SX_W-1], divisor);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         sum_x            <= '0;
         sum_y            <= '0;
         count            <= '0;
         busy             <= 1'b0;
         step             <= '0;
         centroid_x_o     <= '0;
         centroid_y_o     <= '0;
         centroid_valid_o <= 1'b0;
      end else begin
         centroid_valid_o <= 1'b0;
         // sums restart at every frame end
         if (last_pix) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
         end else if (hit) begin
            sum_x <= tot_x;
            sum_y <= tot_y;
            count <= tot_n;
         end
         if (start) begin
            busy <= 1'b1;
            step <= '0;
         end else if (div_run) begin
            step <= step + 1'b1;
         end else if (busy) begin
            // quotients complete
            busy             <= 1'b0;
            centroid_x_o     <= dvd_x[HW-1:0];
            centroid_y_o     <= dvd_y[VW-1:0];
            centroid_valid_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (start) begin
         dvd_x   <= tot_x;
         dvd_y   <= SX_W'(tot_y);
         divisor <= tot_n;
         rem_x   <= '0;
         rem_y   <= '0;
      end else if (div_run) begin
         // quotient bits shift in behind the dividend
         dvd_x <= {dvd_x[SX_W-2:0], nxt_x[0]};
         dvd_y <= {dvd_y[SX_W-2:0], nxt_y[0]};
         rem_x <= nxt_x[CNT_W:1];
         rem_y <= nxt_y[CNT_W:1];
      end
   end

endmodule

/* verilog/telemetry_timer.sv */
`include "tracker_defs.svh"

module telemetry_timer #(
   parameter int BAUD_DIV      = `TRK_BAUD_DIV,
   parameter int REPORT_PERIOD = `TRK_REPORT_PERIOD
) (
   input  logic clk_camera,
   input  logic sys_rst_camera,
   output logic report_tick_o,
   output logic baud_tick_o
);
   // slot keeps its place in the period, a quarter in
   localparam int SLOT = REPORT_PERIOD / (`TRK_REPORT_PERIOD / `TRK_REPORT_SLOT);
   localparam int BW   = $clog2(BAUD_DIV);
   localparam int RW   = $clog2(REPORT_PERIOD);

   logic [BW-1:0] baud_cnt;
   logic [RW-1:0] rep_cnt;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         baud_cnt      <= '0;
         rep_cnt       <= '0;
         report_tick_o <= 1'b0;
         baud_tick_o   <= 1'b0;
      end else begin
         baud_cnt      <= (baud_cnt == BW'(BAUD_DIV - 1)) ? '0 : baud_cnt + 1'b1;
         rep_cnt       <= (rep_cnt == RW'(REPORT_PERIOD - 1)) ? '0 : rep_cnt + 1'b1;
         // one pulse per wrap of each counter
         baud_tick_o   <= (baud_cnt == BW'(BAUD_DIV - 1));
         report_tick_o <= (rep_cnt == RW'(SLOT));
      end
   end

endmodule

/* verilog/telemetry_fsm.sv */
module telemetry_fsm (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  logic                 report_tick_i,
   input  tracker_pkg::hcount_t centroid_x_i,
   input  tracker_pkg::vcount_t centroid_y_i,
   input  logic                 tx_busy_i,
   output logic [7:0]           tx_byte_o,
   output logic                 tx_start_o
);
   import tracker_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT} state_t;

   state_t     state;
   logic [1:0] idx;
   hcount_t    x_q;
   vcount_t    y_q;
   logic [7:0] next_byte;

   // x high (zero-extended), x low, y
   always_comb begin
      case (idx)
         2'd0:    next_byte = 8'(x_q >> 8);
         2'd1:    next_byte = x_q[7:0];
         default: next_byte = 8'(y_q);
      endcase
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state      <= S_IDLE;
         idx        <= '0;
         tx_start_o <= 1'b0;
      end else begin
         tx_start_o <= 1'b0;
         case (state)
            S_IDLE: begin
               // ticks during a report are dropped here
               if (report_tick_i) begin
                  idx   <= '0;
                  state <= S_SEND;
               end
            end
            S_SEND: begin
               if (!tx_busy_i) begin
                  tx_start_o <= 1'b1;
                  state      <= S_WAIT;
               end
            end
            default: begin
               // busy rises a cycle after the start pulse, so wait for it to clear
               if (!tx_start_o && !tx_busy_i) begin
                  idx   <= idx + 1'b1;
                  state <= (idx == 2'd2) ? S_IDLE : S_SEND;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_camera) begin
      if (state == S_IDLE && report_tick_i) begin
         x_q <= centroid_x_i;
         y_q <= centroid_y_i;
      end
      if (state == S_SEND && !tx_busy_i) begin
         tx_byte_o <= next_byte;
      end
   end

endmodule

/* verilog/uart_tx.sv */
module uart_tx (
   input  logic       clk_camera,
   input  logic       sys_rst_camera,
   input  logic       baud_tick_i,
   input  logic [7:0] tx_byte_i,
   input  logic       tx_start_i,
   output logic       tx_busy_o,
   output logic       uart_txd_o
);
   // stop, data lsb first, start in bit 0
   logic [9:0] frame_q;
   logic [3:0] bit_cnt;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         tx_busy_o  <= 1'b0;
         bit_cnt    <= '0;
         uart_txd_o <= 1'b1;
      end else if (!tx_busy_o) begin
         if (tx_start_i) begin
            // line stays idle until the next baud tick
            tx_busy_o <= 1'b1;
            bit_cnt   <= '0;
         end
      end else if (baud_tick_i) begin
         if (bit_cnt == 4'd10) begin
            // stop bit has run a full period
            tx_busy_o  <= 1'b0;
            uart_txd_o <= 1'b1;
         end else begin
            uart_txd_o <= frame_q[0];
            bit_cnt    <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (!tx_busy_o && tx_start_i) begin
         frame_q <= {1'b1, tx_byte_i, 1'b0};
      end else if (tx_busy_o && baud_tick_i) begin
         frame_q <= {1'b1, frame_q[9:1]};
      end
   end

endmodule

/* verilog/color_tracker_top.sv */
`include "tracker_defs.svh"

module color_tracker_top #(
   parameter int FRAME_WIDTH   = `TRK_FRAME_WIDTH,
   parameter int FRAME_HEIGHT  = `TRK_FRAME_HEIGHT,
   parameter int BAUD_DIV      = `TRK_BAUD_DIV,
   parameter int REPORT_PERIOD = `TRK_REPORT_PERIOD
) (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  logic [7:0]           camera_d_i,
   input  logic                 cam_pclk_i,
   input  logic                 cam_hsync_i,
   input  logic                 cam_vsync_i,
   output tracker_pkg::hcount_t centroid_x_o,
   output tracker_pkg::vcount_t centroid_y_o,
   output logic                 centroid_valid_o,
   output logic                 uart_txd_o
);
   // rebuilt pixels
   logic                       pix_valid;
   tracker_pkg::camera_pixel_u pixel;
   tracker_pkg::hcount_t       cap_hcount;
   tracker_pkg::vcount_t       cap_vcount;
   // mask stream
   logic                       mask_valid;
   logic                       mask;
   tracker_pkg::hcount_t       mask_hcount;
   tracker_pkg::vcount_t       mask_vcount;
   // telemetry
   logic                       report_tick;
   logic                       baud_tick;
   logic [7:0]                 tx_byte;
   logic                       tx_start;
   logic                       tx_busy;

   camera_pixel_capture capture_i (
      .clk_camera, .sys_rst_camera, .camera_d_i, .cam_pclk_i, .cam_hsync_i, .cam_vsync_i,
      .pix_valid_o(pix_valid), .pixel_o(pixel), .hcount_o(cap_hcount), .vcount_o(cap_vcount)
   );

   chroma_threshold threshold_i (
      .clk_camera, .sys_rst_camera, .pix_valid_i(pix_valid), .pixel_i(pixel),
      .hcount_i(cap_hcount), .vcount_i(cap_vcount), .mask_valid_o(mask_valid),
      .mask_o(mask), .hcount_o(mask_hcount), .vcount_o(mask_vcount)
   );

   centroid_accumulator #(.FRAME_WIDTH(FRAME_WIDTH), .FRAME_HEIGHT(FRAME_HEIGHT)) centroid_i (
      .clk_camera, .sys_rst_camera, .mask_valid_i(mask_valid), .mask_i(mask),
      .hcount_i(mask_hcount), .vcount_i(mask_vcount), .centroid_x_o, .centroid_y_o,
      .centroid_valid_o
   );

   telemetry_timer #(.BAUD_DIV(BAUD_DIV), .REPORT_PERIOD(REPORT_PERIOD)) timer_i (
      .clk_camera, .sys_rst_camera, .report_tick_o(report_tick), .baud_tick_o(baud_tick)
   );

   // reports read the held centre, not the pulse
   telemetry_fsm fsm_i (
      .clk_camera, .sys_rst_camera, .report_tick_i(report_tick),
      .centroid_x_i(centroid_x_o), .centroid_y_i(centroid_y_o), .tx_busy_i(tx_busy),
      .tx_byte_o(tx_byte), .tx_start_o(tx_start)
   );

   uart_tx uart_i (
      .clk_camera, .sys_rst_camera, .baud_tick_i(baud_tick), .tx_byte_i(tx_byte),
      .tx_start_i(tx_start), .tx_busy_o(tx_busy), .uart_txd_o
   );

endmodule

/* sim/tb_color_tracker.sv */
`include "tracker_defs.svh"

module tb_color_tracker;
   timeunit 1ns;
   timeprecision 1ps;

   import tracker_pkg::*;

   localparam int FW            = 32;
   localparam int FH            = 8;
   localparam int BAUD_DIV      = 16;
   localparam int REPORT_PERIOD = 2048;
   localparam int RESET_CYCLES  = 16;
   localparam int NUM_FRAMES    = 8;
   localparam int GAP_CYCLES    = 16;
   localparam int SETTLE_CYCLES = 64;
   // vsync and lead gap then per line two bytes a pixel at 8 clocks a byte
   localparam int FRAME_CYCLES  = 2 * GAP_CYCLES + FH * (FW * 16 + GAP_CYCLES);
   localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_FRAMES * (FRAME_CYCLES + SETTLE_CYCLES)
                                        + 3 * REPORT_PERIOD);

   logic       clk_camera;
   logic       sys_rst_camera;
   logic [7:0] camera_d_i;
   logic       cam_pclk_i;
   logic       cam_hsync_i;
   logic       cam_vsync_i;
   hcount_t    centroid_x_o;
   vcount_t    centroid_y_o;
   logic       centroid_valid_o;
   logic       uart_txd_o;

   int            cycle_count = 0;
   int            last_pulse_cycle = 0;
   int            model_count;
   hcount_t       model_x;
   vcount_t       model_y;
   // expected centres for frames with masked pixels
   hcount_t       exp_x_q [$];
   vcount_t       exp_y_q [$];
   camera_pixel_u frame_buf [FH][FW];
   camera_pixel_u in_pal [$];
   camera_pixel_u out_pal [$];
   camera_pixel_u bound_in [$];
   camera_pixel_u bound_out [$];
   // received uart bytes and the cycle each start bit was seen
   logic [7:0]    rx_byte_q [$];
   int            rx_start_q [$];

   color_tracker_top #(
      .FRAME_WIDTH(FW), .FRAME_HEIGHT(FH), .BAUD_DIV(BAUD_DIV), .REPORT_PERIOD(REPORT_PERIOD)
   ) color_tracker_top_i (
      .clk_camera, .sys_rst_camera, .camera_d_i, .cam_pclk_i, .cam_hsync_i, .cam_vsync_i,
      .centroid_x_o, .centroid_y_o, .centroid_valid_o, .uart_txd_o
   );

   always #50 clk_camera = ~clk_camera;

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_centroid(input hcount_t got_x, input vcount_t got_y,
                                 input hcount_t exp_x, input vcount_t exp_y, input string what);
      if (got_x !== exp_x || got_y !== exp_y) begin
         stop_with_failure($sformatf("mismatch at %0d ns: %s centre got (%0d,%0d) exp (%0d,%0d)",
                                     $time, what, got_x, got_y, exp_x, exp_y));
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0d ns: %s byte got 0x%02h exp 0x%02h",
                                     $time, what, got, exp));
      end
   endtask

   // red-difference chroma with zero-filled fields and a floor shift then clamped to a byte
   function automatic int chroma_of(input camera_pixel_u p);
      int s;
      int c;
      s = 112 * (int'(p.rgb.red) * 8) - 94 * (int'(p.rgb.green) * 4)
          - 18 * (int'(p.rgb.blue) * 8);
      c = (s >>> 8) + 128;
      if (c < 0) begin
         c = 0;
      end else if (c > 255) begin
         c = 255;
      end
      return c;
   endfunction

   function automatic bit in_window(input int c);
      return (c >= `TRK_CR_LOWER) && (c <= `TRK_CR_UPPER);
   endfunction

   // first colour in the whole rgb565 space with the given chroma
   task automatic find_colour(input int target, output camera_pixel_u w, output bit found);
      camera_pixel_u cand;
      int v;
      found = 1'b0;
      w = '0;
      for (v = 0; v < 65536; v++) begin
         cand = v[15:0];
         if (!found && chroma_of(cand) == target) begin
            w = cand;
            found = 1'b1;
         end
      end
   endtask

   task automatic build_palette();
      camera_pixel_u cand;
      while (in_pal.size() < 8 || out_pal.size() < 8) begin
         cand = 16'($urandom_range(0, 65535));
         if (in_window(chroma_of(cand))) begin
            if (in_pal.size() < 8) in_pal.push_back(cand);
         end else if (out_pal.size() < 8) begin
            out_pal.push_back(cand);
         end
      end
   endtask

   task automatic fill_boundary_frame();
      int r;
      int c;
      for (r = 0; r < FH; r++) begin
         for (c = 0; c < FW; c++) begin
            if ($urandom_range(0, 1) != 0) begin
               frame_buf[r][c] = bound_in[$urandom_range(0, bound_in.size() - 1)];
            end else begin
               frame_buf[r][c] = bound_out[$urandom_range(0, bound_out.size() - 1)];
            end
         end
      end
   endtask

   // dense box of target colour with sparse noise elsewhere
   task automatic fill_random_frame();
      int x0;
      int x1;
      int y0;
      int y1;
      int r;
      int c;
      bit hit;
      x0 = $urandom_range(0, FW - 1);
      x1 = $urandom_range(x0, FW - 1);
      y0 = $urandom_range(0, FH - 1);
      y1 = $urandom_range(y0, FH - 1);
      for (r = 0; r < FH; r++) begin
         for (c = 0; c < FW; c++) begin
            if (c >= x0 && c <= x1 && r >= y0 && r <= y1) begin
               hit = ($urandom_range(0, 3) != 0);
            end else begin
               hit = ($urandom_range(0, 15) == 0);
            end
            if (hit) begin
               frame_buf[r][c] = in_pal[$urandom_range(0, in_pal.size() - 1)];
            end else begin
               frame_buf[r][c] = out_pal[$urandom_range(0, out_pal.size() - 1)];
            end
         end
      end
   endtask

   task automatic fill_empty_frame();
      int r;
      int c;
      for (r = 0; r < FH; r++) begin
         for (c = 0; c < FW; c++) begin
            frame_buf[r][c] = out_pal[$urandom_range(0, out_pal.size() - 1)];
         end
      end
   endtask

   // floored mean of masked coordinates or no update for an empty frame
   task automatic model_frame();
      int sx;
      int sy;
      int n;
      int r;
      int c;
      sx = 0;
      sy = 0;
      n = 0;
      for (r = 0; r < FH; r++) begin
         for (c = 0; c < FW; c++) begin
            if (in_window(chroma_of(frame_buf[r][c]))) begin
               sx += c;
               sy += r;
               n++;
            end
         end
      end
      model_count = n;
      if (n != 0) begin
         model_x = hcount_t'(sx / n);
         model_y = vcount_t'(sy / n);
         exp_x_q.push_back(model_x);
         exp_y_q.push_back(model_y);
      end
   endtask

   // data changes with pclk low and the rising edge comes four clocks later
   task automatic drive_byte(input logic [7:0] b);
      camera_d_i = b;
      cam_pclk_i = 1'b0;
      repeat (4) @(negedge clk_camera);
      cam_pclk_i = 1'b1;
      repeat (4) @(negedge clk_camera);
   endtask

   task automatic drive_frame();
      int r;
      int c;
      cam_vsync_i = 1'b1;
      repeat (GAP_CYCLES) @(negedge clk_camera);
      cam_vsync_i = 1'b0;
      repeat (GAP_CYCLES) @(negedge clk_camera);
      for (r = 0; r < FH; r++) begin
         cam_hsync_i = 1'b1;
         for (c = 0; c < FW; c++) begin
            // high byte first on the wire
            drive_byte(frame_buf[r][c].bus.first);
            drive_byte(frame_buf[r][c].bus.second);
         end
         cam_pclk_i  = 1'b0;
         cam_hsync_i = 1'b0;
         repeat (GAP_CYCLES) @(negedge clk_camera);
      end
   endtask

   always @(posedge clk_camera) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_with_failure($sformatf("timeout after %0d cycles, run did not finish",
                                     cycle_count));
      end
   end

   // every centre pulse must match the oldest pending frame
   always @(negedge clk_camera) begin
      if (sys_rst_camera === 1'b0 && centroid_valid_o === 1'b1) begin
         if (exp_x_q.size() == 0) begin
            stop_with_failure("centroid_valid_o pulsed with no frame of masked pixels pending");
         end else begin
            check_centroid(centroid_x_o, centroid_y_o, exp_x_q.pop_front(),
                           exp_y_q.pop_front(), "pulse");
            last_pulse_cycle = cycle_count;
         end
      end
   end

   // 8N1 receiver sampling near mid-bit
   always begin : uart_receiver
      logic [7:0] rx_data;
      int start_cycle;
      int i;
      @(negedge clk_camera);
      if (sys_rst_camera === 1'b0 && uart_txd_o === 1'b0) begin
         start_cycle = cycle_count;
         repeat (BAUD_DIV / 2) @(negedge clk_camera);
         if (uart_txd_o !== 1'b0) begin
            stop_with_failure("uart start bit did not stay low to mid-bit");
         end
         for (i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk_camera);
            rx_data[i] = uart_txd_o;
         end
         repeat (BAUD_DIV) @(negedge clk_camera);
         if (uart_txd_o !== 1'b1) begin
            stop_with_failure("uart stop bit was not high");
         end
         rx_byte_q.push_back(rx_data);
         rx_start_q.push_back(start_cycle);
      end
   end

   initial begin
      camera_pixel_u colour;
      bit found;
      int seed_draw;
      int f;
      int r;
      int idx;
      int settle;
      clk_camera     = 1'b0;
      sys_rst_camera = 1'b1;
      camera_d_i     = 8'h00;
      cam_pclk_i     = 1'b0;
      cam_hsync_i    = 1'b0;
      cam_vsync_i    = 1'b0;
      model_x        = '0;
      model_y        = '0;
      seed_draw      = $urandom(78);
      build_palette();
      // colours just inside and just outside each bound
      find_colour(160, colour, found);
      if (!found) stop_with_failure("no rgb565 colour has chroma 160");
      bound_in.push_back(colour);
      find_colour(159, colour, found);
      if (!found) stop_with_failure("no rgb565 colour has chroma 159");
      bound_out.push_back(colour);
      find_colour(240, colour, found);
      if (found) bound_in.push_back(colour);
      find_colour(241, colour, found);
      if (found) bound_out.push_back(colour);
      if (bound_in.size() == 1) begin
         $display("note: chroma above 236 is unreachable, upper bound left unexercised");
      end

      repeat (RESET_CYCLES) @(negedge clk_camera);
      sys_rst_camera = 1'b0;
      @(negedge clk_camera);
      if (uart_txd_o !== 1'b1) stop_with_failure("uart_txd_o is not idle high after reset");
      if (centroid_valid_o !== 1'b0) stop_with_failure("centroid_valid_o is high after reset");
      check_centroid(centroid_x_o, centroid_y_o, '0, '0, "reset");

      for (f = 0; f < NUM_FRAMES; f++) begin
         if (f == 0) begin
            fill_boundary_frame();
         end else if (f == 5 || f == NUM_FRAMES - 1) begin
            fill_empty_frame();
         end else begin
            fill_random_frame();
         end
         model_frame();
         drive_frame();
         if (model_count != 0) begin
            while (exp_x_q.size() != 0) @(negedge clk_camera);
         end else begin
            // no pulse may come and the held centre stays
            repeat (SETTLE_CYCLES) @(negedge clk_camera);
            check_centroid(centroid_x_o, centroid_y_o, model_x, model_y, "empty frame");
         end
      end

      // first full report whose latch lies after the last centre update
      settle = last_pulse_cycle + 2 * BAUD_DIV + 8;
      idx = -1;
      while (idx < 0) begin
         @(negedge clk_camera);
         for (r = 0; r + 2 < rx_byte_q.size(); r += 3) begin
            if (idx < 0 && rx_start_q[r] > settle) idx = r;
         end
      end
      check_byte(rx_byte_q[idx], 8'(int'(model_x) / 256), "x high");
      check_byte(rx_byte_q[idx + 1], 8'(int'(model_x) % 256), "x low");
      check_byte(rx_byte_q[idx + 2], 8'(int'(model_y)), "y");

      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+verilog
verilog/tracker_pkg.sv
verilog/camera_pixel_capture.sv
verilog/chroma_threshold.sv
verilog/centroid_accumulator.sv
verilog/telemetry_timer.sv
verilog/telemetry_fsm.sv
verilog/uart_tx.sv
verilog/color_tracker_top.sv
sim/tb_color_tracker.sv
